// File: common/llc_cfg.svh
/* cache geometry, field widths and bit positions inside the mixed tag/state SRAM word */
`ifndef LLC_CFG_SVH
`define LLC_CFG_SVH

`define LLC_WAYS                4
`define LLC_WAY_BITS            2
`define LLC_SET_BITS            6
`define LLC_SETS                64

// two banks per way, chosen by the top set bit
`define LLC_SRAMS_PER_WAY       2
`define LLC_SRAM_INDEX_BITS     1
`define LLC_SRAM_ADDR_WIDTH     5

`define LLC_TAG_BITS            16
`define LLC_OWNER_BITS          4
`define LLC_STATE_BITS          3
`define LLC_SHARERS_BITS        16

`define LLC_LINE_BITS           128
`define LLC_SRAMS_PER_LINE      2
`define LLC_LINE_SLICE_BITS     64

// mixed word layout
`define LLC_MIXED_BITS          28
`define LLC_MIXED_TAG_LO        0
`define LLC_MIXED_TAG_HI        15
`define LLC_MIXED_OWNER_LO      16
`define LLC_MIXED_OWNER_HI      19
`define LLC_MIXED_STATE_LO      20
`define LLC_MIXED_STATE_HI      22
`define LLC_MIXED_DIRTY_IDX     23
`define LLC_MIXED_HPROT_IDX     24
`define LLC_MIXED_PAD_LO        25

`endif

// File: common/llc_pkg.sv
/* vector types of the cache fields and the line state encoding */
`default_nettype none

`include "llc_cfg.svh"

package llc_pkg;

    typedef logic [`LLC_SET_BITS-1:0]     llc_set_t;
    typedef logic [`LLC_WAY_BITS-1:0]     llc_way_t;
    typedef logic [`LLC_TAG_BITS-1:0]     llc_tag_t;

    // id of the owning L2
    typedef logic [`LLC_OWNER_BITS-1:0]   owner_t;

    // one bit per L2 holding a copy
    typedef logic [`LLC_SHARERS_BITS-1:0] sharers_t;

    typedef logic                         hprot_t;
    typedef logic [`LLC_LINE_BITS-1:0]    line_t;

    // a way with INVALID never hits
    typedef enum logic [`LLC_STATE_BITS-1:0] {
        INVALID   = 3'd0,
        VALID     = 3'd1,
        SHARED    = 3'd2,
        EXCLUSIVE = 3'd3,
        MODIFIED  = 3'd4
    } llc_state_t;

endpackage

`default_nettype wire

// File: source/sram_sp_masked.sv
/* behavioral single-port SRAM with bit write mask and registered read */
`timescale 1ns/1ns
`default_nettype none

module sram_sp_masked #(
    parameter int DEPTH_BITS = 5,
    parameter int WIDTH      = 28
) (
    input  logic                  clk,
    input  logic                  ce,
    input  logic                  we,
    input  logic [DEPTH_BITS-1:0] addr,
    input  logic [WIDTH-1:0]      wdata,
    input  logic [WIDTH-1:0]      wmask,
    output logic [WIDTH-1:0]      rdata
);

    logic [WIDTH-1:0] mem [1 << DEPTH_BITS];

    // read returns the old word when written in the same cycle
    always_ff @(posedge clk) begin
        if (ce) begin
            if (we) begin
                mem[addr] <= (mem[addr] & ~wmask) | (wdata & wmask);
            end
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: llc_localmem/llc_localmem.sv
/* per-way banked tag/state, sharers and line storage
   plus the per-set eviction pointer file */
`timescale 1ns/1ns
`default_nettype none

`include "llc_cfg.svh"

module llc_localmem
    import llc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       rd_en,
    input  logic       wr_en,
    input  logic       wr_en_evict_way,
    input  logic [`LLC_WAYS-1:0] wr_rst_flush,
    input  llc_set_t   set_in,
    input  llc_way_t   way,
    input  line_t      wr_data_line,
    input  llc_tag_t   wr_data_tag,
    input  sharers_t   wr_data_sharers,
    input  owner_t     wr_data_owner,
    input  hprot_t     wr_data_hprot,
    input  logic       wr_data_dirty_bit,
    input  llc_state_t wr_data_state,
    input  llc_way_t   wr_data_evict_way,
    output line_t      rd_data_line [`LLC_WAYS],
    output llc_tag_t   rd_data_tag [`LLC_WAYS],
    output sharers_t   rd_data_sharers [`LLC_WAYS],
    output owner_t     rd_data_owner [`LLC_WAYS],
    output hprot_t     rd_data_hprot [`LLC_WAYS],
    output logic       rd_data_dirty_bit [`LLC_WAYS],
    output llc_state_t rd_data_state [`LLC_WAYS],
    output llc_way_t   rd_data_evict_way
);

    logic [`LLC_MIXED_BITS-1:0] rd_mixed [`LLC_WAYS][`LLC_SRAMS_PER_WAY];
    sharers_t                   rd_sharers [`LLC_WAYS][`LLC_SRAMS_PER_WAY];
    line_t                      rd_line [`LLC_WAYS][`LLC_SRAMS_PER_WAY];

    logic [`LLC_WAYS-1:0]           wr_en_way;
    logic [`LLC_SRAMS_PER_WAY-1:0]  bank_hit;
    logic [`LLC_SRAM_INDEX_BITS-1:0] bank_w;
    logic [`LLC_SRAM_INDEX_BITS-1:0] bank_r;
    logic [`LLC_SRAM_ADDR_WIDTH-1:0] sram_addr;
    logic [`LLC_MIXED_BITS-1:0]     wr_data_mixed;
    logic [`LLC_MIXED_BITS-1:0]     wr_mixed_mask;
    logic                           flush_any;
    logic                           sram_ce;
    llc_way_t                       evict_way_arr [`LLC_SETS];

    assign flush_any = |wr_rst_flush;
    assign sram_ce   = rd_en | wr_en | flush_any;
    assign bank_w    = set_in[`LLC_SET_BITS-1 -: `LLC_SRAM_INDEX_BITS];
    assign sram_addr = set_in[`LLC_SRAM_ADDR_WIDTH-1:0];

    // a flush touches every flagged way, a write only the addressed one
    always_comb begin
        for (int i = 0; i < `LLC_WAYS; i++) begin
            wr_en_way[i] = wr_rst_flush[i] | (wr_en & (way == llc_way_t'(i)));
        end
        for (int j = 0; j < `LLC_SRAMS_PER_WAY; j++) begin
            bank_hit[j] = (bank_w == j[`LLC_SRAM_INDEX_BITS-1:0]);
        end
    end

    assign wr_data_mixed = {{(`LLC_MIXED_BITS - `LLC_MIXED_PAD_LO){1'b0}}, wr_data_hprot,
                            wr_data_dirty_bit, wr_data_state, wr_data_owner, wr_data_tag};

    // flush rewrites only state and dirty, tag/owner/hprot are kept
    always_comb begin
        wr_mixed_mask = '0;
        if (wr_en) begin
            wr_mixed_mask[`LLC_MIXED_TAG_HI:`LLC_MIXED_TAG_LO]     = '1;
            wr_mixed_mask[`LLC_MIXED_OWNER_HI:`LLC_MIXED_OWNER_LO] = '1;
            wr_mixed_mask[`LLC_MIXED_HPROT_IDX]                    = 1'b1;
        end
        if (wr_en | flush_any) begin
            wr_mixed_mask[`LLC_MIXED_STATE_HI:`LLC_MIXED_STATE_LO] = '1;
            wr_mixed_mask[`LLC_MIXED_DIRTY_IDX]                    = 1'b1;
        end
    end

    for (genvar i = 0; i < `LLC_WAYS; i++) begin : g_way
        for (genvar j = 0; j < `LLC_SRAMS_PER_WAY; j++) begin : g_bank
            sram_sp_masked #(.DEPTH_BITS(`LLC_SRAM_ADDR_WIDTH), .WIDTH(`LLC_MIXED_BITS)) u_mixed (
                .clk   (clk),
                .ce    (sram_ce),
                .we    (wr_en_way[i] & bank_hit[j]),
                .addr  (sram_addr),
                .wdata (wr_data_mixed),
                .wmask (wr_mixed_mask),
                .rdata (rd_mixed[i][j])
            );

            sram_sp_masked #(.DEPTH_BITS(`LLC_SRAM_ADDR_WIDTH), .WIDTH(`LLC_SHARERS_BITS)) u_sharers (
                .clk   (clk),
                .ce    (sram_ce),
                .we    (wr_en_way[i] & bank_hit[j]),
                .addr  (sram_addr),
                .wdata (wr_data_sharers),
                .wmask ({`LLC_SHARERS_BITS{1'b1}}),
                .rdata (rd_sharers[i][j])
            );

            // line is only written by a full write
            for (genvar k = 0; k < `LLC_SRAMS_PER_LINE; k++) begin : g_slice
                sram_sp_masked #(
                    .DEPTH_BITS (`LLC_SRAM_ADDR_WIDTH),
                    .WIDTH      (`LLC_LINE_SLICE_BITS)
                ) u_line (
                    .clk   (clk),
                    .ce    (sram_ce),
                    .we    (wr_en & wr_en_way[i] & bank_hit[j]),
                    .addr  (sram_addr),
                    .wdata (wr_data_line[k*`LLC_LINE_SLICE_BITS +: `LLC_LINE_SLICE_BITS]),
                    .wmask ({`LLC_LINE_SLICE_BITS{1'b1}}),
                    .rdata (rd_line[i][j][k*`LLC_LINE_SLICE_BITS +: `LLC_LINE_SLICE_BITS])
                );
            end
        end
    end

    // bank of the set read last cycle
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            bank_r <= '0;
        end else if (rd_en) begin
            bank_r <= bank_w;
        end
    end

    always_comb begin
        for (int i = 0; i < `LLC_WAYS; i++) begin
            rd_data_tag[i]       = rd_mixed[i][bank_r][`LLC_MIXED_TAG_HI:`LLC_MIXED_TAG_LO];
            rd_data_owner[i]     = rd_mixed[i][bank_r][`LLC_MIXED_OWNER_HI:`LLC_MIXED_OWNER_LO];
            rd_data_state[i]     = llc_state_t'(
                                   rd_mixed[i][bank_r][`LLC_MIXED_STATE_HI:`LLC_MIXED_STATE_LO]);
            rd_data_dirty_bit[i] = rd_mixed[i][bank_r][`LLC_MIXED_DIRTY_IDX];
            rd_data_hprot[i]     = rd_mixed[i][bank_r][`LLC_MIXED_HPROT_IDX];
            rd_data_sharers[i]   = rd_sharers[i][bank_r];
            rd_data_line[i]      = rd_line[i][bank_r];
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `LLC_SETS; s++) begin
                evict_way_arr[s] <= '0;
            end
            rd_data_evict_way <= '0;
        end else begin
            if (wr_en_evict_way) begin
                evict_way_arr[set_in] <= wr_data_evict_way;
            end
            rd_data_evict_way <= evict_way_arr[set_in];
        end
    end

endmodule

`default_nettype wire

// File: source/llc_lookup.sv
/* command decode, tag compare, hit/victim select and round-robin pointer update */
`timescale 1ns/1ns
`default_nettype none

`include "llc_cfg.svh"

module llc_lookup
    import llc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       lookup_req,
    input  logic       write_req,
    input  logic       flush_req,
    input  llc_set_t   req_set,
    input  llc_tag_t   req_tag,
    input  llc_way_t   req_way,
    input  llc_state_t req_state,
    input  logic       req_dirty,
    input  owner_t     req_owner,
    input  sharers_t   req_sharers,
    input  hprot_t     req_hprot,
    input  line_t      req_line,
    output logic       rsp_valid,
    output logic       rsp_hit,
    output llc_way_t   rsp_way,
    output llc_state_t rsp_state,
    output logic       rsp_dirty,
    output llc_tag_t   rsp_tag,
    output line_t      rsp_line,
    output logic       rd_en,
    output logic       wr_en,
    output logic [`LLC_WAYS-1:0] wr_rst_flush,
    output logic       wr_en_evict_way,
    output llc_set_t   set_in,
    output llc_way_t   way,
    output line_t      wr_data_line,
    output llc_tag_t   wr_data_tag,
    output sharers_t   wr_data_sharers,
    output owner_t     wr_data_owner,
    output hprot_t     wr_data_hprot,
    output logic       wr_data_dirty_bit,
    output llc_state_t wr_data_state,
    output llc_way_t   wr_data_evict_way,
    input  line_t      rd_data_line [`LLC_WAYS],
    input  llc_tag_t   rd_data_tag [`LLC_WAYS],
    input  sharers_t   rd_data_sharers [`LLC_WAYS],
    input  owner_t     rd_data_owner [`LLC_WAYS],
    input  hprot_t     rd_data_hprot [`LLC_WAYS],
    input  logic       rd_data_dirty_bit [`LLC_WAYS],
    input  llc_state_t rd_data_state [`LLC_WAYS],
    input  llc_way_t   rd_data_evict_way
);

    logic     lookup_q;
    llc_set_t set_q;
    llc_tag_t tag_q;
    logic     hit;
    llc_way_t hit_way;
    llc_way_t sel_way;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lookup_q <= 1'b0;
        end else begin
            lookup_q <= lookup_req;
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_req) begin
            set_q <= req_set;
            tag_q <= req_tag;
        end
    end

    // memory side: response cycle reuses the registered set for the pointer write
    assign rd_en        = lookup_req;
    assign wr_en        = write_req;
    assign wr_rst_flush = {`LLC_WAYS{flush_req}};
    assign way          = req_way;
    assign set_in       = lookup_q ? set_q : req_set;

    assign wr_data_tag       = req_tag;
    assign wr_data_owner     = req_owner;
    assign wr_data_hprot     = req_hprot;
    assign wr_data_line      = req_line;
    assign wr_data_state     = flush_req ? INVALID : req_state;
    assign wr_data_dirty_bit = req_dirty & ~flush_req;
    assign wr_data_sharers   = flush_req ? '0 : req_sharers;

    // scan down so the lowest matching way wins
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int i = `LLC_WAYS - 1; i >= 0; i--) begin
            if (rd_data_state[i] != INVALID && rd_data_tag[i] == tag_q) begin
                hit     = 1'b1;
                hit_way = llc_way_t'(i);
            end
        end
    end

    assign sel_way = hit ? hit_way : rd_data_evict_way;

    assign rsp_valid = lookup_q;
    assign rsp_hit   = lookup_q & hit;
    assign rsp_way   = sel_way;
    assign rsp_state = rd_data_state[sel_way];
    assign rsp_dirty = rd_data_dirty_bit[sel_way];
    assign rsp_tag   = rd_data_tag[sel_way];
    assign rsp_line  = rd_data_line[sel_way];

    // round-robin advance on a miss, wraps with the way width
    assign wr_en_evict_way   = lookup_q & ~hit;
    assign wr_data_evict_way = rd_data_evict_way + 1'b1;

endmodule

`default_nettype wire

// File: source/llc_mem_top.sv
/* LLC slice store: lookup front end on top of the banked per-way memory */
`timescale 1ns/1ns
`default_nettype none

`include "llc_cfg.svh"

module llc_mem_top
    import llc_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       lookup_req,
    input  logic       write_req,
    input  logic       flush_req,
    input  llc_set_t   req_set,
    input  llc_tag_t   req_tag,
    input  llc_way_t   req_way,
    input  llc_state_t req_state,
    input  logic       req_dirty,
    input  owner_t     req_owner,
    input  sharers_t   req_sharers,
    input  hprot_t     req_hprot,
    input  line_t      req_line,
    output logic       rsp_valid,
    output logic       rsp_hit,
    output llc_way_t   rsp_way,
    output llc_state_t rsp_state,
    output logic       rsp_dirty,
    output llc_tag_t   rsp_tag,
    output line_t      rsp_line
);

    logic                 rd_en;
    logic                 wr_en;
    logic [`LLC_WAYS-1:0] wr_rst_flush;
    logic                 wr_en_evict_way;
    llc_set_t             set_in;
    llc_way_t             way;
    line_t                wr_data_line;
    llc_tag_t             wr_data_tag;
    sharers_t             wr_data_sharers;
    owner_t               wr_data_owner;
    hprot_t               wr_data_hprot;
    logic                 wr_data_dirty_bit;
    llc_state_t           wr_data_state;
    llc_way_t             wr_data_evict_way;

    line_t      rd_data_line [`LLC_WAYS];
    llc_tag_t   rd_data_tag [`LLC_WAYS];
    sharers_t   rd_data_sharers [`LLC_WAYS];
    owner_t     rd_data_owner [`LLC_WAYS];
    hprot_t     rd_data_hprot [`LLC_WAYS];
    logic       rd_data_dirty_bit [`LLC_WAYS];
    llc_state_t rd_data_state [`LLC_WAYS];
    llc_way_t   rd_data_evict_way;

    llc_lookup u_lookup (
        .clk               (clk),
        .rst               (rst),
        .lookup_req        (lookup_req),
        .write_req         (write_req),
        .flush_req         (flush_req),
        .req_set           (req_set),
        .req_tag           (req_tag),
        .req_way           (req_way),
        .req_state         (req_state),
        .req_dirty         (req_dirty),
        .req_owner         (req_owner),
        .req_sharers       (req_sharers),
        .req_hprot         (req_hprot),
        .req_line          (req_line),
        .rsp_valid         (rsp_valid),
        .rsp_hit           (rsp_hit),
        .rsp_way           (rsp_way),
        .rsp_state         (rsp_state),
        .rsp_dirty         (rsp_dirty),
        .rsp_tag           (rsp_tag),
        .rsp_line          (rsp_line),
        .rd_en             (rd_en),
        .wr_en             (wr_en),
        .wr_rst_flush      (wr_rst_flush),
        .wr_en_evict_way   (wr_en_evict_way),
        .set_in            (set_in),
        .way               (way),
        .wr_data_line      (wr_data_line),
        .wr_data_tag       (wr_data_tag),
        .wr_data_sharers   (wr_data_sharers),
        .wr_data_owner     (wr_data_owner),
        .wr_data_hprot     (wr_data_hprot),
        .wr_data_dirty_bit (wr_data_dirty_bit),
        .wr_data_state     (wr_data_state),
        .wr_data_evict_way (wr_data_evict_way),
        .rd_data_line      (rd_data_line),
        .rd_data_tag       (rd_data_tag),
        .rd_data_sharers   (rd_data_sharers),
        .rd_data_owner     (rd_data_owner),
        .rd_data_hprot     (rd_data_hprot),
        .rd_data_dirty_bit (rd_data_dirty_bit),
        .rd_data_state     (rd_data_state),
        .rd_data_evict_way (rd_data_evict_way)
    );

    llc_localmem u_localmem (
        .clk               (clk),
        .rst               (rst),
        .rd_en             (rd_en),
        .wr_en             (wr_en),
        .wr_en_evict_way   (wr_en_evict_way),
        .wr_rst_flush      (wr_rst_flush),
        .set_in            (set_in),
        .way               (way),
        .wr_data_line      (wr_data_line),
        .wr_data_tag       (wr_data_tag),
        .wr_data_sharers   (wr_data_sharers),
        .wr_data_owner     (wr_data_owner),
        .wr_data_hprot     (wr_data_hprot),
        .wr_data_dirty_bit (wr_data_dirty_bit),
        .wr_data_state     (wr_data_state),
        .wr_data_evict_way (wr_data_evict_way),
        .rd_data_line      (rd_data_line),
        .rd_data_tag       (rd_data_tag),
        .rd_data_sharers   (rd_data_sharers),
        .rd_data_owner     (rd_data_owner),
        .rd_data_hprot     (rd_data_hprot),
        .rd_data_dirty_bit (rd_data_dirty_bit),
        .rd_data_state     (rd_data_state),
        .rd_data_evict_way (rd_data_evict_way)
    );

endmodule

`default_nettype wire

// File: verification/llc_mem_props.sv
/* command spacing and response timing assertions, bound into llc_mem_top */
`timescale 1ns/1ns
`default_nettype none

module llc_mem_props (
    input logic clk,
    input logic rst,
    input logic lookup_req,
    input logic write_req,
    input logic flush_req,
    input logic rsp_valid
);

    logic cmd;

    assign cmd = lookup_req | write_req | flush_req;

    // no back-pressure, so every command needs an idle cycle behind it
    cmd_spacing: assert property (@(posedge clk) disable iff (!rst) cmd |=> !cmd)
        else $error("command issued in the cycle right after a command");

    one_cmd: assert property (@(posedge clk) disable iff (!rst)
                              $onehot0({lookup_req, write_req, flush_req}))
        else $error("more than one command in a cycle");

    rsp_timing: assert property (@(posedge clk) disable iff (!rst)
                                 rsp_valid == $past(lookup_req))
        else $error("rsp_valid not exactly one cycle after lookup_req");

endmodule

bind llc_mem_top llc_mem_props u_props (
    .clk        (clk),
    .rst        (rst),
    .lookup_req (lookup_req),
    .write_req  (write_req),
    .flush_req  (flush_req),
    .rsp_valid  (rsp_valid)
);

`default_nettype wire

// File: verification/tb_llc_mem.sv
/* testbench for the LLC slice store
   replays the stimulus file, checks lookup responses and prints a summary */
`timescale 1ns/1ns
`default_nettype none

`include "llc_cfg.svh"

module tb_llc_mem
    import llc_pkg::*;
();

    logic       clk;
    logic       rst;
    logic       lookup_req;
    logic       write_req;
    logic       flush_req;
    llc_set_t   req_set;
    llc_tag_t   req_tag;
    llc_way_t   req_way;
    llc_state_t req_state;
    logic       req_dirty;
    owner_t     req_owner;
    sharers_t   req_sharers;
    hprot_t     req_hprot;
    line_t      req_line;
    logic       rsp_valid;
    logic       rsp_hit;
    llc_way_t   rsp_way;
    llc_state_t rsp_state;
    logic       rsp_dirty;
    llc_tag_t   rsp_tag;
    line_t      rsp_line;

    string stim_text[$];
    int    stim_line_no[$];
    int    cycle_limit;
    int    cycle_cnt;
    int    lookups;
    int    responses;
    int    errors;
    int    tests;
    int    group_lookups;
    int    group_errors;

    // tag last written into each way, kept across a flush
    llc_tag_t tag_model [`LLC_SETS][`LLC_WAYS];
    bit       tag_known [`LLC_SETS][`LLC_WAYS];

    llc_mem_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .lookup_req  (lookup_req),
        .write_req   (write_req),
        .flush_req   (flush_req),
        .req_set     (req_set),
        .req_tag     (req_tag),
        .req_way     (req_way),
        .req_state   (req_state),
        .req_dirty   (req_dirty),
        .req_owner   (req_owner),
        .req_sharers (req_sharers),
        .req_hprot   (req_hprot),
        .req_line    (req_line),
        .rsp_valid   (rsp_valid),
        .rsp_hit     (rsp_hit),
        .rsp_way     (rsp_way),
        .rsp_state   (rsp_state),
        .rsp_dirty   (rsp_dirty),
        .rsp_tag     (rsp_tag),
        .rsp_line    (rsp_line)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // limit is set once the stimulus is loaded
    always @(posedge clk) begin
        cycle_cnt++;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout: run did not end within %0d cycles", cycle_limit);
            $display("Testbench failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (rsp_valid === 1'b1) begin
            responses++;
        end
    end

    task automatic count_error();
        errors++;
        group_errors++;
    endtask

    task automatic load_stimulus(output bit ok);
        int    fd;
        int    line_no;
        string text;
        fd = $fopen("verification/llc_stimulus.txt", "r");
        ok = (fd != 0);
        line_no = 0;
        while (ok && !$feof(fd)) begin
            text = "";
            if ($fgets(text, fd) != 0) begin
                line_no++;
                while (text.len() > 0 && (text.getc(text.len() - 1) == "\n" ||
                                          text.getc(text.len() - 1) == "\r")) begin
                    text = text.substr(0, text.len() - 2);
                end
                // skip blank and comment lines
                if (text.len() > 0 && text.getc(0) != "#") begin
                    stim_text.push_back(text);
                    stim_line_no.push_back(line_no);
                end
            end
        end
        if (ok) begin
            $fclose(fd);
        end
    endtask

    task automatic send_write(input llc_set_t set, input llc_tag_t tag, input llc_way_t way,
                              input llc_state_t state, input logic dirty, input owner_t owner,
                              input sharers_t sharers, input hprot_t hprot, input line_t line);
        @(posedge clk);
        write_req   <= 1'b1;
        req_set     <= set;
        req_tag     <= tag;
        req_way     <= way;
        req_state   <= state;
        req_dirty   <= dirty;
        req_owner   <= owner;
        req_sharers <= sharers;
        req_hprot   <= hprot;
        req_line    <= line;
        @(posedge clk);
        write_req   <= 1'b0;
    endtask

    task automatic send_flush(input llc_set_t set);
        @(posedge clk);
        flush_req <= 1'b1;
        req_set   <= set;
        @(posedge clk);
        flush_req <= 1'b0;
    endtask

    task automatic check_lookup(input int line_no, input llc_set_t set, input llc_tag_t tag,
                                input logic exp_hit, input llc_way_t exp_way,
                                input logic [2:0] exp_state, input logic exp_dirty,
                                input line_t exp_line);
        @(posedge clk);
        lookup_req <= 1'b1;
        req_set    <= set;
        req_tag    <= tag;
        @(posedge clk);
        lookup_req <= 1'b0;
        lookups++;
        group_lookups++;
        // response is due in the idle cycle right behind the command
        @(negedge clk);
        if (rsp_valid !== 1'b1) begin
            $display("line %0d: lookup of set %h tag %h got no response in the next cycle",
                     line_no, set, tag);
            count_error();
        end else begin
            if (rsp_hit !== exp_hit) begin
                $display("FAIL line %0d rsp_hit: got %h, expected %h", line_no, rsp_hit, exp_hit);
                count_error();
            end
            if (rsp_way !== exp_way) begin
                $display("FAIL line %0d rsp_way: got %h, expected %h", line_no, rsp_way, exp_way);
                count_error();
            end
            if (rsp_state !== exp_state) begin
                $display("FAIL line %0d rsp_state: got %h, expected %h",
                         line_no, rsp_state, exp_state);
                count_error();
            end
            if (rsp_dirty !== exp_dirty) begin
                $display("FAIL line %0d rsp_dirty: got %h, expected %h",
                         line_no, rsp_dirty, exp_dirty);
                count_error();
            end
            if (rsp_line !== exp_line) begin
                $display("FAIL line %0d rsp_line: got %h, expected %h",
                         line_no, rsp_line, exp_line);
                count_error();
            end
            // hit or victim, the reported way returns its stored tag
            if (tag_known[set][exp_way] && rsp_tag !== tag_model[set][exp_way]) begin
                $display("FAIL line %0d rsp_tag: got %h, expected %h",
                         line_no, rsp_tag, tag_model[set][exp_way]);
                count_error();
            end
        end
    endtask

    task automatic run_line(input string text, input int line_no);
        byte        op;
        string      args;
        int         n;
        bit         ok;
        llc_set_t   f_set;
        llc_tag_t   f_tag;
        llc_way_t   f_way;
        logic [2:0] f_state;
        logic       f_dirty;
        logic       f_hit;
        owner_t     f_owner;
        sharers_t   f_sharers;
        hprot_t     f_hprot;
        line_t      f_line;
        op   = text.getc(0);
        args = text.substr(1, text.len() - 1);
        ok   = 1'b0;
        if (op == "W") begin
            n  = $sscanf(args, "%h %h %h %h %h %h %h %h %h", f_set, f_tag, f_way, f_state,
                         f_dirty, f_owner, f_sharers, f_hprot, f_line);
            ok = (n == 9);
            if (ok) begin
                send_write(f_set, f_tag, f_way, llc_state_t'(f_state), f_dirty, f_owner,
                           f_sharers, f_hprot, f_line);
                tag_model[f_set][f_way] = f_tag;
                tag_known[f_set][f_way] = 1'b1;
            end
        end else if (op == "F") begin
            n  = $sscanf(args, "%h", f_set);
            ok = (n == 1);
            if (ok) begin
                send_flush(f_set);
            end
        end else if (op == "L") begin
            n  = $sscanf(args, "%h %h %h %h %h %h %h", f_set, f_tag, f_hit, f_way, f_state,
                         f_dirty, f_line);
            ok = (n == 7);
            if (ok) begin
                check_lookup(line_no, f_set, f_tag, f_hit, f_way, f_state, f_dirty, f_line);
            end
        end else if (op == "T") begin
            ok = 1'b1;
            tests++;
            $display("test %s: %0d lookups, %0d errors", text.substr(2, text.len() - 1),
                     group_lookups, group_errors);
            group_lookups = 0;
            group_errors  = 0;
        end
        if (!ok) begin
            $display("line %0d: stimulus line could not be parsed", line_no);
            count_error();
        end
    endtask

    initial begin
        bit loaded;
        rst         = 1'b0;
        lookup_req  = 1'b0;
        write_req   = 1'b0;
        flush_req   = 1'b0;
        req_set     = '0;
        req_tag     = '0;
        req_way     = '0;
        req_state   = INVALID;
        req_dirty   = 1'b0;
        req_owner   = '0;
        req_sharers = '0;
        req_hprot   = 1'b0;
        req_line    = '0;
        cycle_limit = 0;
        cycle_cnt   = 0;
        lookups     = 0;
        responses   = 0;
        errors      = 0;
        tests       = 0;
        group_lookups = 0;
        group_errors  = 0;
        load_stimulus(loaded);
        if (!loaded) begin
            $display("stimulus file verification/llc_stimulus.txt could not be opened");
            $display("Testbench failed");
            $finish;
        end else begin
            cycle_limit = 3 * stim_text.size() + 20;
            repeat (4) @(posedge clk);
            rst <= 1'b1;
            foreach (stim_text[i]) begin
                run_line(stim_text[i], stim_line_no[i]);
            end
            @(posedge clk);
            if (responses != lookups) begin
                $display("%0d responses seen for %0d lookups", responses, lookups);
                errors++;
            end
            $display("summary: %0d tests, %0d lookups, %0d errors", tests, lookups, errors);
            if (errors == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: verification/llc_stimulus.txt
# W set tag way state dirty owner sharers hprot line | F set | T test_name
# L set tag exp_hit exp_way exp_state exp_dirty exp_line, all fields in hex
W 03 a000 0 1 0 1 0002 1 0303030303030303a0a0a0a0a0a0a0a0
W 03 a001 1 2 0 2 0004 0 1313131313131313a1a1a1a1a1a1a1a1
W 03 a002 2 3 0 3 0008 1 2323232323232323a2a2a2a2a2a2a2a2
W 03 a003 3 4 1 4 0010 0 3333333333333333a3a3a3a3a3a3a3a3
W 23 b000 0 4 1 5 0020 1 0404040404040404b0b0b0b0b0b0b0b0
W 23 b001 1 3 0 6 0040 0 1414141414141414b1b1b1b1b1b1b1b1
W 23 b002 2 2 0 7 0080 1 2424242424242424b2b2b2b2b2b2b2b2
W 23 b003 3 1 0 8 0100 0 3434343434343434b3b3b3b3b3b3b3b3
L 03 a000 1 0 1 0 0303030303030303a0a0a0a0a0a0a0a0
L 03 a001 1 1 2 0 1313131313131313a1a1a1a1a1a1a1a1
L 03 a002 1 2 3 0 2323232323232323a2a2a2a2a2a2a2a2
L 03 a003 1 3 4 1 3333333333333333a3a3a3a3a3a3a3a3
L 23 b000 1 0 4 1 0404040404040404b0b0b0b0b0b0b0b0
L 23 b001 1 1 3 0 1414141414141414b1b1b1b1b1b1b1b1
L 23 b002 1 2 2 0 2424242424242424b2b2b2b2b2b2b2b2
L 23 b003 1 3 1 0 3434343434343434b3b3b3b3b3b3b3b3
T write_hit
W 03 a012 2 4 1 9 0200 1 2626262626262626a6a6a6a6a6a6a6a6
L 23 b002 1 2 2 0 2424242424242424b2b2b2b2b2b2b2b2
L 23 b000 1 0 4 1 0404040404040404b0b0b0b0b0b0b0b0
L 03 a012 1 2 4 1 2626262626262626a6a6a6a6a6a6a6a6
T bank_independence
L 23 c000 0 0 4 1 0404040404040404b0b0b0b0b0b0b0b0
L 23 c001 0 1 3 0 1414141414141414b1b1b1b1b1b1b1b1
L 23 c002 0 2 2 0 2424242424242424b2b2b2b2b2b2b2b2
L 23 c003 0 3 1 0 3434343434343434b3b3b3b3b3b3b3b3
L 23 c004 0 0 4 1 0404040404040404b0b0b0b0b0b0b0b0
T miss_round_robin
F 03
L 03 a000 0 0 0 0 0303030303030303a0a0a0a0a0a0a0a0
L 03 a003 0 1 0 0 1313131313131313a1a1a1a1a1a1a1a1
L 23 b001 1 1 3 0 1414141414141414b1b1b1b1b1b1b1b1
W 03 a000 0 1 0 1 0002 1 0303030303030303a0a0a0a0a0a0a0a0
L 03 a000 1 0 1 0 0303030303030303a0a0a0a0a0a0a0a0
T flush
W 23 d111 1 4 1 a 0400 1 5555555555555555d1d1d1d1d1d1d1d1
L 23 d111 1 1 4 1 5555555555555555d1d1d1d1d1d1d1d1
L 23 b001 0 1 4 1 5555555555555555d1d1d1d1d1d1d1d1
L 23 b000 1 0 4 1 0404040404040404b0b0b0b0b0b0b0b0
L 23 b002 1 2 2 0 2424242424242424b2b2b2b2b2b2b2b2
L 23 b003 1 3 1 0 3434343434343434b3b3b3b3b3b3b3b3
T overwrite

// File: filelist.f
+incdir+common
common/llc_pkg.sv
source/sram_sp_masked.sv
llc_localmem/llc_localmem.sv
source/llc_lookup.sv
source/llc_mem_top.sv
verification/llc_mem_props.sv
verification/tb_llc_mem.sv

// File: Makefile
VERILATOR := verilator
FLAGS     := --binary --timing --assert -j 0
TOP       := tb_llc_mem
FILELIST  := filelist.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "Testbench passed" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -Wall --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
